// File: dev_scc.f
hw/scc_pkg.sv
hw/scc_channel.sv
hw/scc_wave.sv
hw/dev_scc.sv
test/dev_scc_checker.sv
test/dev_scc_tb.sv

// File: hw/dev_scc.sv
`timescale 1ns/1ps

module dev_scc
    import scc_pkg::*;
(
    input  logic       cpu_bus,
    input  logic       rst_n,
    input  logic       ce_tone,
    input  logic       req,
    input  logic       rd,
    input  logic       wr,
    input  bus_addr_t  addr,
    input  bus_data_t  wdata,
    output bus_data_t  data,
    input  dev_type_t  dev_type,
    input  logic       dev_num,
    input  logic       dev_en,
    input  logic       cfg_valid,
    input  logic       cfg_mode,
    input  logic       cfg_plus,
    input  logic [1:0] chip_en,
    output mix_sound_t sound
);

    // Latched configuration with one bit per chip
    logic [1:0] scc_mode;
    logic [1:0] scc_plus;

    // A valid access to this device type before the chip number is applied
    logic       dev_access;
    logic [1:0] sel;

    // Read tracking for the cycle after the access
    logic rd_q;
    logic rd_chip_q;

    bus_data_t   chip_rdata [2];
    chip_sound_t chip_wave [2];

    always_ff @(posedge cpu_bus) begin
        if (!rst_n) begin
            scc_mode <= 2'b00;
            scc_plus <= 2'b00;
        end else if (cfg_valid && dev_type == DEV_SCC) begin
            scc_mode[dev_num] <= cfg_mode;
            scc_plus[dev_num] <= cfg_plus;
        end
    end

    // Exactly one of rd and wr must accompany req
    assign dev_access = req && (rd != wr) && dev_en && (dev_type == DEV_SCC);
    assign sel[0] = dev_access && !dev_num;
    assign sel[1] = dev_access && dev_num;

    always_ff @(posedge cpu_bus) begin
        if (!rst_n) begin
            rd_q <= 1'b0;
        end else begin
            rd_q <= dev_access && rd;
        end
    end

    // Chip number of the latest read steers data in the following cycle
    always_ff @(posedge cpu_bus) begin
        if (dev_access && rd) begin
            rd_chip_q <= dev_num;
        end
    end

    genvar i;
    generate
        for (i = 0; i < 2; i++) begin : gen_chip
            scc_wave u_wave (
                .cpu_bus   (cpu_bus),
                .rst_n     (rst_n),
                .ce        (ce_tone),
                .sel       (sel[i]),
                .wr        (wr),
                .plus_chip (scc_plus[i]),
                .plus_mode (scc_mode[i]),
                .addr      (addr),
                .wdata     (wdata),
                .rdata     (chip_rdata[i]),
                .wave      (chip_wave[i])
            );
        end
    endgenerate

    // The bus idles high unless the previous cycle was a read of this device
    assign data = rd_q ? chip_rdata[rd_chip_q] : BUS_IDLE;

    // Each chip is sign-extended to the output width before the add
    assign sound = (chip_en[0] ? mix_sound_t'(chip_wave[0]) : '0)
                 + (chip_en[1] ? mix_sound_t'(chip_wave[1]) : '0);

endmodule

// File: hw/scc_channel.sv
`timescale 1ns/1ps

module scc_channel
    import scc_pkg::*;
(
    input  logic    cpu_bus,
    input  logic    rst_n,
    input  logic    ce,
    input  period_t period,
    output logic [4:0] ptr
);

    // Down-counter that runs at the tone clock enable rate
    period_t cnt;

    // A period below the minimum stops the oscillator
    logic stopped;

    assign stopped = (period < PERIOD_MIN);

    always_ff @(posedge cpu_bus) begin
        if (!rst_n) begin
            cnt <= '0;
            ptr <= '0;
        end else if (ce) begin
            if (stopped) begin
                // Keep the counter loaded so the tone restarts with a full period
                cnt <= period;
            end else if (cnt == '0) begin
                // Expiry reloads the period and steps to the next sample
                cnt <= period;
                // The five bit pointer wraps at the end of the 32 byte table
                ptr <= ptr + 5'd1;
            end else begin
                cnt <= cnt - 12'd1;
            end
        end
    end

endmodule

// File: hw/scc_pkg.sv
package scc_pkg;

    // CPU side of the chip window
    typedef logic [7:0] bus_addr_t;
    typedef logic [7:0] bus_data_t;

    // One signed byte of a waveform table
    typedef logic signed [7:0] wave_sample_t;

    // Tone period and channel volume as held in the register block
    typedef logic [11:0] period_t;
    typedef logic [3:0] volume_t;

    // Sample times volume, the widest product is -128 * 15
    typedef logic signed [11:0] chan_out_t;

    // Five channel products added together
    typedef logic signed [14:0] chip_sound_t;

    // Both chips added together at the device output
    typedef logic signed [15:0] mix_sound_t;

    // Device type as seen on the configuration port and the select lines
    typedef logic [3:0] dev_type_t;

    localparam dev_type_t DEV_SCC = 4'h5;

    localparam int NUM_CHANNELS = 5;
    localparam int WAVE_LEN = 32;
    localparam int WAVE_BYTES = NUM_CHANNELS * WAVE_LEN;

    // Register block start in the two address maps
    localparam bus_addr_t REG_BASE_NORMAL = 8'h80;
    localparam bus_addr_t REG_BASE_PLUS = 8'hA0;

    // Offsets inside the register block, periods occupy 0 to 9
    localparam logic [3:0] REG_OFS_VOLUME = 4'd10;
    localparam logic [3:0] REG_OFS_ENABLE = 4'd15;

    // Periods below this value stop the waveform pointer
    localparam period_t PERIOD_MIN = 12'd9;

    // Value seen on the data bus when nothing is being read
    localparam bus_data_t BUS_IDLE = 8'hFF;

endpackage

// File: hw/scc_wave.sv
`timescale 1ns/1ps

module scc_wave
    import scc_pkg::*;
(
    input  logic        cpu_bus,
    input  logic        rst_n,
    input  logic        ce,
    input  logic        sel,
    input  logic        wr,
    input  logic        plus_chip,
    input  logic        plus_mode,
    input  bus_addr_t   addr,
    input  bus_data_t   wdata,
    output bus_data_t   rdata,
    output chip_sound_t wave
);

    // The enhanced map needs both the chip flag and the mode bit
    logic      plus_active;
    bus_addr_t reg_base;

    // Address classification for the active map
    logic       in_wave;
    logic       in_reg;
    logic [3:0] reg_ofs;
    logic [2:0] per_idx;
    logic [2:0] vol_idx;

    // Waveform RAM, channel n owns bytes 32n to 32n+31
    wave_sample_t ram [WAVE_BYTES];

    // Register block contents
    period_t                 period [NUM_CHANNELS];
    volume_t                 volume [NUM_CHANNELS];
    logic [NUM_CHANNELS-1:0] enable_mask;

    // Oscillator outputs and the mixer path
    logic [4:0]   ptr [NUM_CHANNELS];
    wave_sample_t sample [NUM_CHANNELS];
    chan_out_t    prod [NUM_CHANNELS];
    chip_sound_t  mix_sum;

    // Delayed tone enable so the mixer sees the pointers after they step
    logic ce_d;

    assign plus_active = plus_chip & plus_mode;
    assign reg_base = plus_active ? REG_BASE_PLUS : REG_BASE_NORMAL;

    // Everything below the register block is waveform space in both maps
    assign in_wave = (addr < reg_base);
    // Both bases sit on a 16 byte boundary, so the upper nibble picks the block
    assign in_reg = (addr[7:4] == reg_base[7:4]);
    assign reg_ofs = addr[3:0];
    assign per_idx = reg_ofs[3:1];
    assign vol_idx = 3'(reg_ofs - REG_OFS_VOLUME);

    // In normal mode 0x60 to 0x7F lands in channel 4's bytes directly
    always_ff @(posedge cpu_bus) begin
        if (sel && wr && in_wave) begin
            ram[addr] <= wave_sample_t'(wdata);
        end
    end

    always_ff @(posedge cpu_bus) begin
        if (!rst_n) begin
            for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
                period[ch] <= '0;
                volume[ch] <= '0;
            end
            enable_mask <= '0;
        end else if (sel && wr && in_reg) begin
            if (reg_ofs < REG_OFS_VOLUME) begin
                // Even offsets carry the low byte, odd ones the high nibble
                if (reg_ofs[0]) begin
                    period[per_idx][11:8] <= wdata[3:0];
                end else begin
                    period[per_idx][7:0] <= wdata;
                end
            end else if (reg_ofs < REG_OFS_ENABLE) begin
                volume[vol_idx] <= wdata[3:0];
            end else begin
                enable_mask <= wdata[NUM_CHANNELS-1:0];
            end
        end
    end

    // Reads only update on a selected read, so the byte holds in between
    always_ff @(posedge cpu_bus) begin
        if (!rst_n) begin
            rdata <= BUS_IDLE;
        end else if (sel && !wr) begin
            // Register offsets and unmapped space are not readable
            rdata <= in_wave ? bus_data_t'(ram[addr]) : BUS_IDLE;
        end
    end

    genvar g;
    generate
        for (g = 0; g < NUM_CHANNELS; g++) begin : gen_chan
            scc_channel u_chan (
                .cpu_bus (cpu_bus),
                .rst_n   (rst_n),
                .ce      (ce),
                .period  (period[g]),
                .ptr     (ptr[g])
            );
        end
    endgenerate

    always_comb begin
        mix_sum = '0;
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            // Channel 5 borrows channel 4's table unless the plus map is active
            if (ch == NUM_CHANNELS - 1 && !plus_active) begin
                sample[ch] = ram[{3'(ch - 1), ptr[ch]}];
            end else begin
                sample[ch] = ram[{3'(ch), ptr[ch]}];
            end
            // Both factors are widened first so the product keeps all its bits
            if (enable_mask[ch]) begin
                prod[ch] = chan_out_t'(sample[ch]) * chan_out_t'($signed({1'b0, volume[ch]}));
            end else begin
                prod[ch] = '0;
            end
            mix_sum = mix_sum + chip_sound_t'(prod[ch]);
        end
    end

    always_ff @(posedge cpu_bus) begin
        if (!rst_n) begin
            ce_d <= 1'b0;
            wave <= '0;
        end else begin
            ce_d <= ce;
            if (ce_d) begin
                wave <= mix_sum;
            end
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds the dev_scc testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module dev_scc_tb \
    -f dev_scc.f \
    -Mdir obj_dir -o dev_scc_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

# A high error limit lets the testbench report assertion failures itself
./obj_dir/dev_scc_sim +verilator+error+limit+100
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
fi
exit $status

// File: test/dev_scc_checker.sv
`timescale 1ns/1ps

module dev_scc_checker
    import scc_pkg::*;
(
    input logic       cpu_bus,
    input logic       rst_n,
    input logic       req,
    input logic       rd,
    input logic       wr,
    input logic       dev_en,
    input dev_type_t  dev_type,
    input bus_data_t  data,
    input mix_sound_t sound
);

    // Count of failed assertions, watched from the testbench
    int violations = 0;

    // A read cycle addressed to this device type
    logic dev_read;

    assign dev_read = req && rd && !wr && dev_en && (dev_type == DEV_SCC);

    // The bus idles high in the cycle after anything but a device read
    assert property (@(posedge cpu_bus) disable iff (!rst_n) !dev_read |=> data == BUS_IDLE)
        else begin
            violations++;
            $error("data is not 0xFF after a cycle without a device read");
        end

    // Reset is synchronous, so the output is checked one edge into reset
    assert property (@(posedge cpu_bus) !rst_n |=> sound == '0)
        else begin
            violations++;
            $error("sound is not 0 during reset");
        end

    assert property (@(posedge cpu_bus) disable iff (!rst_n) !(req && rd && wr))
        else begin
            violations++;
            $error("rd and wr are both high with req");
        end

    assert property (@(posedge cpu_bus) disable iff (!rst_n) !$isunknown(data))
        else begin
            violations++;
            $error("data is unknown after reset");
        end

endmodule

bind dev_scc dev_scc_checker u_checker (
    .cpu_bus  (cpu_bus),
    .rst_n    (rst_n),
    .req      (req),
    .rd       (rd),
    .wr       (wr),
    .dev_en   (dev_en),
    .dev_type (dev_type),
    .data     (data),
    .sound    (sound)
);

// File: test/dev_scc_tb.sv
`timescale 1ns/1ps

module dev_scc_tb
    import scc_pkg::*;
;

    logic       cpu_bus;
    logic       rst_n;
    logic       ce_tone;
    logic       req;
    logic       rd;
    logic       wr;
    bus_addr_t  addr;
    bus_data_t  wdata;
    bus_data_t  data;
    dev_type_t  dev_type;
    logic       dev_num;
    logic       dev_en;
    logic       cfg_valid;
    logic       cfg_mode;
    logic       cfg_plus;
    logic [1:0] chip_en;
    mix_sound_t sound;

    // Testbench copy of what each chip should hold with one constant sample per table
    wave_sample_t tone_model [2][NUM_CHANNELS];
    volume_t      vol_model [2][NUM_CHANNELS];
    logic [4:0]   mask_model [2];
    logic         plus_on [2];

    // Bytes written to the waveform space of both chips
    bus_data_t shadow [2][128];

    logic [1:0] ce_div;
    event       settled;

    dev_scc DUT (.*);

    always #20 cpu_bus = ~cpu_bus;

    // Tone enable is one cycle wide and repeats every 4 cycles
    always @(negedge cpu_bus) begin
        ce_div = ce_div + 2'd1;
        ce_tone = (ce_div == 2'd0);
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Testbench failed");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_data(input string name, input bus_data_t got, input bus_data_t exp);
        if (got !== exp) begin
            $display("FAILED %s: expected 0x%h, got 0x%h", name, exp, got);
            abort_run("data mismatch on the CPU bus");
        end
    endtask

    task automatic check_sound(input string name, input mix_sound_t got, input mix_sound_t exp);
        if (got !== exp) begin
            $display("FAILED %s: expected 0x%h, got 0x%h", name, exp, got);
            abort_run("sound mismatch at the device output");
        end
    endtask

    // Sum over enabled chips and channels of sample times volume
    function automatic mix_sound_t expected_sound(input logic [1:0] en);
        int total;
        int src;
        total = 0;
        for (int c = 0; c < 2; c++) begin
            if (en[c]) begin
                for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
                    // Channel 5 plays channel 4's table outside the plus map
                    src = (ch == NUM_CHANNELS - 1 && !plus_on[c]) ? ch - 1 : ch;
                    if (mask_model[c][ch]) begin
                        total += int'(tone_model[c][src]) * int'(vol_model[c][ch]);
                    end
                end
            end
        end
        return mix_sound_t'(total);
    endfunction

    // Compares sound with the reference each time the output has settled
    always @(settled) begin
        check_sound("sound", sound, expected_sound(chip_en));
    end

    // Any assertion failure in the bound checker ends the run
    always @(negedge cpu_bus) begin
        if (DUT.u_checker.violations != 0) begin
            abort_run("an assertion in dev_scc_checker fired");
        end
    end

    // One bus cycle is driven on the falling edge and the bus then goes idle
    task automatic access(input logic chip, input bus_addr_t a, input bus_data_t d,
                          input logic is_read, input dev_type_t dtype, input logic en);
        @(negedge cpu_bus);
        req = 1'b1;
        rd = is_read;
        wr = !is_read;
        addr = a;
        wdata = d;
        dev_num = chip;
        dev_type = dtype;
        dev_en = en;
        @(negedge cpu_bus);
        req = 1'b0;
        rd = 1'b0;
        wr = 1'b0;
    endtask

    task automatic write_byte(input logic chip, input bus_addr_t a, input bus_data_t d);
        access(chip, a, d, 1'b0, DEV_SCC, 1'b1);
    endtask

    // The read data is valid from the edge after the access until the next edge
    task automatic read_check(input logic chip, input bus_addr_t a, input bus_data_t exp);
        access(chip, a, 8'h00, 1'b1, DEV_SCC, 1'b1);
        check_data("data", data, exp);
    endtask

    task automatic configure(input logic chip, input logic mode, input logic plus);
        @(negedge cpu_bus);
        cfg_valid = 1'b1;
        dev_type = DEV_SCC;
        dev_num = chip;
        cfg_mode = mode;
        cfg_plus = plus;
        @(negedge cpu_bus);
        cfg_valid = 1'b0;
        plus_on[chip] = mode & plus;
    endtask

    // Fills one 32 byte table with a single value
    task automatic load_tone(input logic chip, input int ch, input wave_sample_t value);
        for (int i = 0; i < WAVE_LEN; i++) begin
            write_byte(chip, bus_addr_t'(ch * WAVE_LEN + i), bus_data_t'(value));
        end
        tone_model[chip][ch] = value;
    endtask

    // Writes period 20, random volumes and the given mask through the map at base
    task automatic load_regs(input logic chip, input bus_addr_t base, input logic [4:0] mask);
        volume_t v;
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            v = volume_t'($urandom_range(15));
            write_byte(chip, base + bus_addr_t'(2 * ch), 8'd20);
            write_byte(chip, base + bus_addr_t'(2 * ch + 1), 8'd0);
            write_byte(chip, base + bus_addr_t'(10 + ch), bus_data_t'(v));
            vol_model[chip][ch] = v;
        end
        write_byte(chip, base + 8'd15, bus_data_t'(mask));
        mask_model[chip] = mask;
    endtask

    // Waits until sound has held for 12 cycles, which spans three tone pulses
    task automatic settle_sound();
        mix_sound_t last;
        int stable;
        int cycles;
        last = sound;
        stable = 0;
        cycles = 0;
        while (stable < 12) begin
            @(negedge cpu_bus);
            cycles++;
            if (cycles > 300) begin
                abort_run("timeout waiting for sound to settle");
            end
            if (sound == last) begin
                stable++;
            end else begin
                stable = 0;
                last = sound;
            end
        end
        -> settled;
        @(posedge cpu_bus);
    endtask

    initial begin
        void'($urandom(69090));
        cpu_bus = 1'b0;
        rst_n = 1'b0;
        ce_tone = 1'b0;
        ce_div = 2'd0;
        req = 1'b0;
        rd = 1'b0;
        wr = 1'b0;
        addr = '0;
        wdata = '0;
        dev_type = '0;
        dev_num = 1'b0;
        dev_en = 1'b0;
        cfg_valid = 1'b0;
        cfg_mode = 1'b0;
        cfg_plus = 1'b0;
        // Both chips pass to the output so reset has to clear their waves
        chip_en = 2'b11;
        for (int c = 0; c < 2; c++) begin
            mask_model[c] = '0;
            plus_on[c] = 1'b0;
        end
        repeat (5) @(posedge cpu_bus);
        @(negedge cpu_bus);
        rst_n = 1'b1;

        // Idle bus and silent output straight after reset
        @(negedge cpu_bus);
        check_data("data", data, BUS_IDLE);
        check_sound("sound", sound, '0);

        // Waveform bytes read back, register offsets read as idle
        for (int c = 0; c < 2; c++) begin
            for (int a = 0; a < 128; a++) begin
                shadow[c][a] = bus_data_t'($urandom_range(255));
                write_byte(1'(c), bus_addr_t'(a), shadow[c][a]);
            end
        end
        for (int c = 0; c < 2; c++) begin
            for (int a = 0; a < 128; a++) begin
                read_check(1'(c), bus_addr_t'(a), shadow[c][a]);
            end
            for (int a = 128; a < 144; a++) begin
                read_check(1'(c), bus_addr_t'(a), BUS_IDLE);
            end
        end

        // Writes to another device type or without dev_en are ignored
        access(1'b0, 8'h10, ~shadow[0][16], 1'b0, dev_type_t'(DEV_SCC + 4'd1), 1'b1);
        access(1'b0, 8'h10, ~shadow[0][16], 1'b0, DEV_SCC, 1'b0);
        access(1'b1, 8'h22, ~shadow[1][34], 1'b0, DEV_SCC, 1'b0);
        read_check(1'b0, 8'h10, shadow[0][16]);
        read_check(1'b1, 8'h22, shadow[1][34]);

        // Constant tables in normal mode, then every chip_en combination
        for (int c = 0; c < 2; c++) begin
            for (int ch = 0; ch < NUM_CHANNELS - 1; ch++) begin
                load_tone(1'(c), ch, wave_sample_t'($urandom_range(255)));
            end
        end
        load_regs(1'b0, REG_BASE_NORMAL, 5'h1F);
        load_regs(1'b1, REG_BASE_NORMAL, 5'($urandom_range(31)));
        for (int e = 0; e < 4; e++) begin
            @(negedge cpu_bus);
            chip_en = 2'(e);
            settle_sound();
        end

        // Chip 1 in the plus map owns channel 5's table at 0x80
        configure(1'b1, 1'b1, 1'b1);
        load_tone(1'b1, NUM_CHANNELS - 1, wave_sample_t'($urandom_range(255)));
        for (int a = 128; a < 160; a++) begin
            read_check(1'b1, bus_addr_t'(a), bus_data_t'(tone_model[1][NUM_CHANNELS - 1]));
        end
        load_regs(1'b1, REG_BASE_PLUS, 5'h1F);
        settle_sound();

        // Without the plus flag the normal map and shared table come back
        configure(1'b1, 1'b1, 1'b0);
        settle_sound();
        vol_model[1][0] = volume_t'($urandom_range(15));
        write_byte(1'b1, REG_BASE_NORMAL + 8'd10, bus_data_t'(vol_model[1][0]));
        read_check(1'b1, REG_BASE_NORMAL, BUS_IDLE);
        settle_sound();

        // A stopped pointer on a constant table leaves the sum unchanged
        write_byte(1'b0, REG_BASE_NORMAL, 8'd5);
        write_byte(1'b0, REG_BASE_NORMAL + 8'd1, 8'd0);
        settle_sound();
        write_byte(1'b0, REG_BASE_NORMAL + 8'd15, 8'h00);
        write_byte(1'b1, REG_BASE_NORMAL + 8'd15, 8'h00);
        mask_model[0] = '0;
        mask_model[1] = '0;
        settle_sound();
        check_sound("sound", sound, '0);

        @(negedge cpu_bus);
        if (DUT.u_checker.violations != 0) begin
            abort_run("an assertion in dev_scc_checker fired");
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule
